/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_desc64_frontend
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= -j 0
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+hdl
hdl/desc64_pkg.sv
hdl/desc64_reg_file.sv
hdl/desc64_addr_fifo.sv
hdl/desc64_reg_wrapper.sv
hdl/desc64_frontend_top.sv
tb/tb_clk_gen.sv
tb/desc64_frontend_props.sv
tb/tb_desc64_frontend.sv

/* hdl/desc64_addr_fifo.sv */
/*
 * descriptor address queue.
 * circular buffer with a valid/ready pop side and a fill level for status.
 */
`timescale 1ns/1ps
`include "desc64_macros.svh"

module desc64_addr_fifo #(
    parameter int unsigned DEPTH = `DESC64_FIFO_DEPTH
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       push_valid_i,
    output logic                       push_ready_o,
    input  logic [`DESC64_DW-1:0]      push_data_i,
    output logic                       pop_valid_o,
    input  logic                       pop_ready_i,
    output logic [`DESC64_DW-1:0]      pop_data_o,
    output desc64_pkg::desc64_hw2reg_t hw2reg_o
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [`DESC64_DW-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      count_q;
    logic                  push;
    logic                  pop;

    // wraps at DEPTH so that any depth works, not only powers of two.
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ready_o = (count_q != CNT_W'(DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;

    // oldest entry stays on the output until it is taken.
    assign pop_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            // push and pop together leave the level alone.
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign hw2reg_o.fifo_level = 8'(count_q);
    assign hw2reg_o.fifo_full  = !push_ready_o;

endmodule

/* hdl/desc64_frontend_top.sv */
/*
 * descriptor DMA register front end.
 * register file, back-pressure wrapper and descriptor address queue.
 */
`timescale 1ns/1ps
`include "desc64_macros.svh"

module desc64_frontend_top (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  desc64_pkg::desc64_reg_req_t reg_req_i,
    output desc64_pkg::desc64_reg_rsp_t reg_rsp_o,
    output logic [`DESC64_DW-1:0]       desc_addr_o,
    output logic                        desc_valid_o,
    input  logic                        desc_ready_i,
    input  logic                        done_i
);

    import desc64_pkg::*;

    desc64_reg_req_t file_req;
    desc64_reg_rsp_t file_rsp;
    desc64_reg2hw_t  reg2hw;
    desc64_hw2reg_t  hw2reg;
    logic            push_valid;
    logic            push_ready;

    desc64_reg_file u_reg_file (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .reg_req_i (file_req),
        .reg_rsp_o (file_rsp),
        .reg2hw_o  (reg2hw),
        .hw2reg_i  (hw2reg),
        .done_i    (done_i)
    );

    desc64_reg_wrapper u_reg_wrapper (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .reg_req_i    (reg_req_i),
        .reg_rsp_o    (reg_rsp_o),
        .file_req_o   (file_req),
        .file_rsp_i   (file_rsp),
        .reg2hw_i     (reg2hw),
        .fifo_valid_o (push_valid),
        .fifo_ready_i (push_ready)
    );

    desc64_addr_fifo #(
        .DEPTH (`DESC64_FIFO_DEPTH)
    ) u_addr_fifo (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_valid_i (push_valid),
        .push_ready_o (push_ready),
        .push_data_i  (reg2hw.desc_addr_q),
        .pop_valid_o  (desc_valid_o),
        .pop_ready_i  (desc_ready_i),
        .pop_data_o   (desc_addr_o),
        .hw2reg_o     (hw2reg)
    );

endmodule

/* hdl/desc64_macros.svh */
/*
 * descriptor front end parameters.
 * bus widths, register map and default queue depth.
 */
`ifndef DESC64_MACROS_SVH
`define DESC64_MACROS_SVH

// register bus widths.
`define DESC64_DW 64
`define DESC64_AW 8

// register map, byte addresses on the register bus.
`define DESC64_DESC_ADDR_OFFSET 8'h00
`define DESC64_STATUS_OFFSET 8'h08
`define DESC64_DONE_OFFSET 8'h10

// default number of queued descriptor addresses.
`define DESC64_FIFO_DEPTH 4

`endif

/* hdl/desc64_pkg.sv */
/*
 * descriptor front end types.
 * register bus request and response, and the hardware side of the registers.
 */
`include "desc64_macros.svh"

package desc64_pkg;

    // host request on the register bus.
    typedef struct packed {
        logic                     valid;
        logic                     write;
        logic [`DESC64_AW-1:0]    addr;
        logic [`DESC64_DW-1:0]    wdata;
        logic [`DESC64_DW/8-1:0]  wstrb;
    } desc64_reg_req_t;

    // response returned to the host.
    typedef struct packed {
        logic                  ready;
        logic [`DESC64_DW-1:0] rdata;
        logic                  error;
    } desc64_reg_rsp_t;

    // register file toward the wrapper and the queue.
    typedef struct packed {
        logic [`DESC64_DW-1:0] desc_addr_q;
        logic                  desc_addr_qe;
    } desc64_reg2hw_t;

    // queue state seen by the status register.
    typedef struct packed {
        logic [7:0] fifo_level;
        logic       fifo_full;
    } desc64_hw2reg_t;

endpackage

/* hdl/desc64_reg_file.sv */
/*
 * descriptor front end register file.
 * decodes the register bus, serves status and completion count reads,
 * and strobes each descriptor address write toward the queue.
 */
`timescale 1ns/1ps
`include "desc64_macros.svh"

module desc64_reg_file (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  desc64_pkg::desc64_reg_req_t reg_req_i,
    output desc64_pkg::desc64_reg_rsp_t reg_rsp_o,
    output desc64_pkg::desc64_reg2hw_t  reg2hw_o,
    input  desc64_pkg::desc64_hw2reg_t  hw2reg_i,
    input  logic                        done_i
);

    logic                  sel_desc;
    logic                  sel_status;
    logic                  sel_done;
    logic                  desc_we;
    logic [`DESC64_DW-1:0] desc_addr_q;
    logic [`DESC64_DW-1:0] desc_addr_wr;
    logic [`DESC64_DW-1:0] done_cnt_q;

    assign sel_desc   = (reg_req_i.addr == `DESC64_DESC_ADDR_OFFSET);
    assign sel_status = (reg_req_i.addr == `DESC64_STATUS_OFFSET);
    assign sel_done   = (reg_req_i.addr == `DESC64_DONE_OFFSET);

    // the descriptor address register is write only.
    assign desc_we = reg_req_i.valid && reg_req_i.write && sel_desc;

    // merge the enabled bytes over the held address.
    always_comb begin
        desc_addr_wr = desc_addr_q;
        for (int i = 0; i < `DESC64_DW/8; i++) begin
            if (reg_req_i.wstrb[i]) begin
                desc_addr_wr[8*i +: 8] = reg_req_i.wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (desc_we) begin
            desc_addr_q <= desc_addr_wr;
        end
    end

    // written value goes out in the same cycle as the strobe.
    assign reg2hw_o.desc_addr_q  = desc_we ? desc_addr_wr : desc_addr_q;
    assign reg2hw_o.desc_addr_qe = desc_we;

    // one count per completion pulse from the fetcher.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_cnt_q <= '0;
        end else if (done_i) begin
            done_cnt_q <= done_cnt_q + 1'b1;
        end
    end

    // every request completes in the cycle it is presented.
    assign reg_rsp_o.ready = reg_req_i.valid;

    always_comb begin
        reg_rsp_o.rdata = '0;
        if (!reg_req_i.write) begin
            if (sel_status) begin
                reg_rsp_o.rdata[`DESC64_DW-1] = hw2reg_i.fifo_full;
                reg_rsp_o.rdata[7:0]          = hw2reg_i.fifo_level;
            end else if (sel_done) begin
                reg_rsp_o.rdata = done_cnt_q;
            end
        end
    end

    // unmapped address, write to a read-only register or read of the write-only one.
    always_comb begin
        reg_rsp_o.error = 1'b0;
        if (reg_req_i.valid) begin
            if (!(sel_desc || sel_status || sel_done)) begin
                reg_rsp_o.error = 1'b1;
            end else if (reg_req_i.write && (sel_status || sel_done)) begin
                reg_rsp_o.error = 1'b1;
            end else if (!reg_req_i.write && sel_desc) begin
                reg_rsp_o.error = 1'b1;
            end
        end
    end

endmodule

/* hdl/desc64_reg_wrapper.sv */
/*
 * register bus back-pressure for the descriptor queue.
 * stalls descriptor address writes while the queue is full and turns
 * each accepted write into a push.
 */
`timescale 1ns/1ps
`include "desc64_macros.svh"

module desc64_reg_wrapper (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  desc64_pkg::desc64_reg_req_t reg_req_i,
    output desc64_pkg::desc64_reg_rsp_t reg_rsp_o,
    output desc64_pkg::desc64_reg_req_t file_req_o,
    input  desc64_pkg::desc64_reg_rsp_t file_rsp_i,
    input  desc64_pkg::desc64_reg2hw_t  reg2hw_i,
    output logic                        fifo_valid_o,
    input  logic                        fifo_ready_i
);

    logic is_desc;

    assign is_desc = (reg_req_i.addr == `DESC64_DESC_ADDR_OFFSET);

    // hold the request back from the register file while the queue is full.
    always_comb begin
        file_req_o = reg_req_i;
        if (is_desc) begin
            file_req_o.valid = reg_req_i.valid && fifo_ready_i;
        end
    end

    // queue state only matters for accesses to the descriptor address.
    always_comb begin
        reg_rsp_o = file_rsp_i;
        if (is_desc) begin
            reg_rsp_o.ready = file_rsp_i.ready && fifo_ready_i;
        end
    end

    // the strobe only fires while the queue has room.
    assign fifo_valid_o = reg2hw_i.desc_addr_qe;

endmodule

/* tb/desc64_frontend_props.sv */
/*
 * descriptor front end protocol checks, bound into the top level.
 */
`timescale 1ns/1ps
`include "desc64_macros.svh"

module desc64_frontend_props (
    input logic                        clk_i,
    input logic                        arst_n_i,
    input desc64_pkg::desc64_reg_req_t reg_req_i,
    input desc64_pkg::desc64_reg_rsp_t reg_rsp_i,
    input logic                        push_valid_i,
    input logic [`DESC64_DW-1:0]       desc_addr_i,
    input logic                        desc_valid_i,
    input logic                        desc_ready_i
);

    localparam int unsigned DEPTH = `DESC64_FIFO_DEPTH;

    int unsigned err_push = 0;
    int unsigned err_hold = 0;
    int unsigned err_full = 0;
    int unsigned err_map  = 0;
    int unsigned err_cnt;
    logic        desc_req;
    logic        unmapped;
    logic        desc_wr_done;
    logic        desc_pop;
    logic [7:0]  occ_q;

    assign err_cnt  = err_push + err_hold + err_full + err_map;
    assign desc_req = reg_req_i.valid && (reg_req_i.addr == `DESC64_DESC_ADDR_OFFSET);
    assign unmapped = (reg_req_i.addr != `DESC64_DESC_ADDR_OFFSET) &&
                      (reg_req_i.addr != `DESC64_STATUS_OFFSET) &&
                      (reg_req_i.addr != `DESC64_DONE_OFFSET);

    assign desc_wr_done = desc_req && reg_req_i.write && reg_rsp_i.ready;
    assign desc_pop     = desc_valid_i && desc_ready_i;

    // queue occupancy as seen from the bus and the fetcher.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            occ_q <= '0;
        end else if (desc_wr_done && !desc_pop) begin
            occ_q <= occ_q + 1'b1;
        end else if (desc_pop && !desc_wr_done) begin
            occ_q <= occ_q - 1'b1;
        end
    end

    // an accepted descriptor address write pushes in the same cycle.
    a_push_on_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        desc_req && reg_req_i.write && reg_rsp_i.ready |-> push_valid_i)
        else begin
            $error("descriptor address write accepted without a push");
            err_push++;
        end

    // the fetcher sees a stable descriptor until it takes it.
    a_desc_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        desc_valid_i && !desc_ready_i |=> desc_valid_i && $stable(desc_addr_i))
        else begin
            $error("descriptor output dropped or changed before it was taken");
            err_hold++;
        end

    a_no_ready_when_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(desc_req && reg_rsp_i.ready && (occ_q == DEPTH)))
        else begin
            $error("descriptor address access completed while the queue was full");
            err_full++;
        end

    a_unmapped_error: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        reg_req_i.valid && unmapped |-> reg_rsp_i.ready && reg_rsp_i.error)
        else begin
            $error("unmapped address completed without an error");
            err_map++;
        end

endmodule

/* tb/tb_clk_gen.sv */
/*
 * testbench clock and reset.
 * free-running clock, reset held low for the first two cycles.
 */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    initial begin
        arst_n_o <= 1'b0;
        repeat (2) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

/* tb/tb_desc64_frontend.sv */
/*
 * descriptor front end testbench.
 * bus writes and reads against the queue, pop stalls and completion pulses.
 */
`timescale 1ns/1ps
`include "desc64_macros.svh"

module tb_desc64_frontend;

    import desc64_pkg::*;

    localparam int CLK_NS = 10;
    localparam int DEPTH  = `DESC64_FIFO_DEPTH;
    // cycle budget of all tests, doubled by the watchdog.
    localparam int STIM_CYCLES = 20 + 12 * 16 + 60 + (DEPTH + 1) * 16 + 40 + 60;

    logic                  clk;
    logic                  arst_n;
    desc64_reg_req_t       reg_req;
    desc64_reg_rsp_t       reg_rsp;
    logic [`DESC64_DW-1:0] desc_addr;
    logic                  desc_valid;
    logic                  desc_ready;
    logic                  done;
    logic [`DESC64_DW-1:0] expected[$];
    logic [`DESC64_DW-1:0] popped[$];
    int                    ready_mode = 0;
    int                    check_errs = 0;
    int                    errs_start = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    tb_clk_gen #(.PERIOD_NS(CLK_NS)) u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    desc64_frontend_top u_dut (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .reg_req_i    (reg_req),
        .reg_rsp_o    (reg_rsp),
        .desc_addr_o  (desc_addr),
        .desc_valid_o (desc_valid),
        .desc_ready_i (desc_ready),
        .done_i       (done)
    );

    bind desc64_frontend_top desc64_frontend_props u_props (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .reg_req_i    (reg_req_i),
        .reg_rsp_i    (reg_rsp_o),
        .push_valid_i (push_valid),
        .desc_addr_i  (desc_addr_o),
        .desc_valid_i (desc_valid_o),
        .desc_ready_i (desc_ready_i)
    );

    function automatic int total_errs();
        return check_errs + int'(u_dut.u_props.err_cnt);
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            check_errs++;
        end
    endtask

    task automatic start_request(input logic wr, input logic [`DESC64_AW-1:0] addr,
                                 input logic [63:0] data);
        @(posedge clk);
        reg_req <= '{1'b1, wr, addr, data, 8'hff};
    endtask

    // sample mid-cycle, release the bus after the completing edge.
    task automatic wait_response(output logic [63:0] rdata, output logic err);
        @(negedge clk);
        while (!reg_rsp.ready) begin
            @(negedge clk);
        end
        rdata = reg_rsp.rdata;
        err   = reg_rsp.error;
        @(posedge clk);
        reg_req.valid <= 1'b0;
    endtask

    task automatic access(input logic wr, input logic [`DESC64_AW-1:0] addr,
                          input logic [63:0] data, output logic [63:0] rdata,
                          output logic err);
        start_request(wr, addr, data);
        wait_response(rdata, err);
    endtask

    task automatic write_desc(input logic [63:0] addr);
        logic [63:0] rdata;
        logic        err;
        access(1'b1, `DESC64_DESC_ADDR_OFFSET, addr, rdata, err);
        check_value("descriptor write error", 64'(err), 64'd0);
        expected.push_back(addr);
    endtask

    // 0 holds the fetcher off, 1 takes every entry, 2 stalls at random.
    task automatic set_ready_mode(input int mode);
        @(negedge clk);
        ready_mode = mode;
    endtask

    task automatic wait_pops(input int n);
        while (popped.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic compare_order(input string what);
        check_value({what, " count"}, 64'(popped.size()), 64'(expected.size()));
        for (int i = 0; i < expected.size() && i < popped.size(); i++) begin
            check_value(what, popped[i], expected[i]);
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        errs       = total_errs() - errs_start;
        errs_start = total_errs();
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, errs);
        expected.delete();
        popped.delete();
    endtask

    initial begin
        desc_ready <= 1'b0;
        forever begin
            @(posedge clk);
            if (ready_mode == 2) begin
                desc_ready <= 1'($urandom);
            end else begin
                desc_ready <= (ready_mode == 1);
            end
        end
    end

    // entry seen with valid and ready leaves at the next edge.
    always @(negedge clk) begin
        if (desc_valid && desc_ready) begin
            popped.push_back(desc_addr);
        end
    end

    initial begin
        #(STIM_CYCLES * 2 * CLK_NS + 500);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [63:0] rdata;
        logic [63:0] addr;
        logic [63:0] snap_status;
        logic [63:0] snap_done;
        logic        err;
        int          k;
        int          pops_done;
        void'($urandom(32'h607c_1fc2));
        reg_req <= '0;
        done    <= 1'b0;
        @(posedge arst_n);

        set_ready_mode(1);
        write_desc({$urandom, $urandom});
        wait_pops(1);
        compare_order("single push");
        report_test("single push");

        set_ready_mode(2);
        repeat (12) write_desc({$urandom, $urandom});
        wait_pops(12);
        compare_order("ordering");
        report_test("ordering under pop stalls");

        // fill the queue, then one more write has to wait for a pop.
        set_ready_mode(0);
        repeat (DEPTH) write_desc({$urandom, $urandom});
        addr = {$urandom, $urandom};
        start_request(1'b1, `DESC64_DESC_ADDR_OFFSET, addr);
        repeat (3) begin
            @(negedge clk);
            check_value("ready while full", 64'(reg_rsp.ready), 64'd0);
        end
        set_ready_mode(1);
        // pops counted at an edge have left the queue by the next sample.
        pops_done = 0;
        do begin
            @(posedge clk);
            pops_done = popped.size();
            @(negedge clk);
        end while (!reg_rsp.ready);
        check_value("stalled write error", 64'(reg_rsp.error), 64'd0);
        check_value("pop before stalled write", 64'(pops_done >= 1), 64'd1);
        @(posedge clk);
        reg_req.valid <= 1'b0;
        expected.push_back(addr);
        wait_pops(DEPTH + 1);
        compare_order("back-pressure");
        report_test("back-pressure");

        set_ready_mode(0);
        for (int n = 0; n <= DEPTH; n++) begin
            if (n > 0) begin
                write_desc({$urandom, $urandom});
            end
            access(1'b0, `DESC64_STATUS_OFFSET, '0, rdata, err);
            check_value("status level", 64'(rdata[7:0]), 64'(n));
            check_value("status full", 64'(rdata[63]), 64'(n == DEPTH));
        end
        set_ready_mode(1);
        wait_pops(DEPTH);
        compare_order("status drain");
        report_test("status");

        k = 3 + int'($urandom % 6);
        repeat (k) begin
            @(posedge clk);
            done <= 1'b1;
            @(posedge clk);
            done <= 1'b0;
        end
        access(1'b0, `DESC64_DONE_OFFSET, '0, rdata, err);
        check_value("completion count", rdata, 64'(k));
        report_test("completion counter");

        set_ready_mode(0);
        write_desc({$urandom, $urandom});
        access(1'b0, `DESC64_STATUS_OFFSET, '0, snap_status, err);
        access(1'b0, `DESC64_DONE_OFFSET, '0, snap_done, err);
        access(1'b0, 8'h18, '0, rdata, err);
        check_value("unmapped read error", 64'(err), 64'd1);
        access(1'b1, `DESC64_STATUS_OFFSET, '1, rdata, err);
        check_value("status write error", 64'(err), 64'd1);
        access(1'b0, `DESC64_DESC_ADDR_OFFSET, '0, rdata, err);
        check_value("descriptor read error", 64'(err), 64'd1);
        access(1'b0, `DESC64_STATUS_OFFSET, '0, rdata, err);
        check_value("status after errors", rdata, snap_status);
        access(1'b0, `DESC64_DONE_OFFSET, '0, rdata, err);
        check_value("count after errors", rdata, snap_done);
        set_ready_mode(1);
        wait_pops(1);
        compare_order("error drain");
        report_test("errors");

        $display("tests run %0d, tests failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, check_errs, u_dut.u_props.err_cnt);
        if (tests_failed == 0 && total_errs() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
